// File: files.f
+incdir+test
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_muldiv.sv
verilog/ex_result_stage.sv
verilog/ex_top.sv
test/tb_ex_top.sv

// File: test/tb_ex_cases.svh
function automatic void load_cases();
    // Columns: name, op, rd, wen, use_imm, src1, src2, imm, pc,
    // expected wdata, expected taken, expected target
    add_case("add_reg", OP_ADD, 1, 1, 0, 'h5, 'h7, 'h0, 'h0, 'hC, 0, 'h0);
    add_case("add_imm", OP_ADD, 2, 1, 1, 'h10000000, 'h99, 'hFFFFFFFF, 'h0, 'h0FFFFFFF, 0, 'h0);
    add_case("sub_reg", OP_SUB, 3, 1, 0, 'h3, 'h5, 'h0, 'h0, 'hFFFFFFFE, 0, 'h0);
    add_case("and_reg", OP_AND, 4, 1, 0, 'hF0F0F0F0, 'hFF00FF00, 'h0, 'h0, 'hF000F000, 0, 'h0);
    add_case("or_imm", OP_OR, 5, 1, 1, 'hF0F0F0F0, 'h1, 'hF, 'h0, 'hF0F0F0FF, 0, 'h0);
    add_case("xor_reg", OP_XOR, 6, 1, 0, 'hAAAA5555, 'hFFFF0000, 'h0, 'h0, 'h55555555, 0, 'h0);
    add_case("nor_reg", OP_NOR, 7, 1, 0, 'h0F0F0000, 'hF0, 'h0, 'h0, 'hF0F0FF0F, 0, 'h0);
    add_case("orn_reg", OP_ORN, 8, 1, 0, 'h1, 'hFFFFFF00, 'h0, 'h0, 'hFF, 0, 'h0);
    add_case("andn_imm", OP_ANDN, 9, 1, 1, 'h12345678, 'h0, 'hFFFF, 'h0, 'h12340000, 0, 'h0);
    // Only the low five bits of the amount count
    add_case("sll_imm", OP_SLL, 10, 1, 1, 'h3, 'h0, 'h24, 'h0, 'h30, 0, 'h0);
    add_case("srl_reg", OP_SRL, 11, 1, 0, 'h80000000, 'h1F, 'h0, 'h0, 'h1, 0, 'h0);
    add_case("sra_reg", OP_SRA, 12, 1, 0, 'h80000010, 'h4, 'h0, 'h0, 'hF8000001, 0, 'h0);
    add_case("slt_reg", OP_SLT, 13, 1, 0, 'hFFFFFFFF, 'h1, 'h0, 'h0, 'h1, 0, 'h0);
    add_case("sltu_reg", OP_SLTU, 14, 1, 0, 'hFFFFFFFF, 'h1, 'h0, 'h0, 'h0, 0, 'h0);
    add_case("slt_imm", OP_SLT, 15, 1, 1, 'h5, 'h0, 'hFFFFFFFB, 'h0, 'h0, 0, 'h0);
    add_case("sltu_imm", OP_SLTU, 16, 1, 1, 'h5, 'h0, 'hFFFFFFFB, 'h0, 'h1, 0, 'h0);
    add_case("lui_reg", OP_LUI, 19, 0, 0, 'h0, 'h12345000, 'h0, 'h0, 'h12345000, 0, 'h0);
    add_case("lui_imm", OP_LUI, 20, 1, 1, 'h0, 'h7, 'hABCDE000, 'h0, 'hABCDE000, 0, 'h0);
    add_case("pcadd_imm", OP_PCADD, 21, 1, 1, 'h0, 'h0, 'h2000, 'h1000, 'h3000, 0, 'h0);
    // Branches, link data is pc+4
    add_case("b", OP_B, 0, 0, 0, 'h0, 'h0, 'h40, 'h100, 'h0, 1, 'h140);
    add_case("bl", OP_BL, 1, 1, 0, 'h0, 'h0, 'hFFFFFFF0, 'h200, 'h204, 1, 'h1F0);
    add_case("jirl", OP_JIRL, 1, 1, 0, 'h8000, 'h0, 'h10, 'h300, 'h304, 1, 'h8010);
    add_case("beq_t", OP_BEQ, 0, 0, 1, 'h55, 'h55, 'h20, 'h400, 'h0, 1, 'h420);
    add_case("beq_nt", OP_BEQ, 0, 0, 0, 'h55, 'h56, 'h20, 'h400, 'h0, 0, 'h420);
    add_case("bne_t", OP_BNE, 0, 0, 0, 'h55, 'h56, 'h20, 'h400, 'h0, 1, 'h420);
    add_case("blt_t", OP_BLT, 0, 0, 0, 'hFFFFFFFE, 'h1, 'h8, 'h500, 'h0, 1, 'h508);
    add_case("bge_nt", OP_BGE, 0, 0, 0, 'hFFFFFFFE, 'h1, 'h8, 'h500, 'h0, 0, 'h508);
    add_case("bge_eq", OP_BGE, 0, 0, 0, 'h7, 'h7, 'h8, 'h500, 'h0, 1, 'h508);
    add_case("bltu_nt", OP_BLTU, 0, 0, 0, 'hFFFFFFFE, 'h1, 'h8, 'h500, 'h0, 0, 'h508);
    add_case("bgeu_t", OP_BGEU, 0, 0, 0, 'hFFFFFFFE, 'h1, 'h8, 'h500, 'h0, 1, 'h508);
    // Multi-cycle unit
    add_case("mul_neg", OP_MUL, 22, 1, 0, 'hFFFFFFFD, 'h7, 'h0, 'h0, 'hFFFFFFEB, 0, 'h0);
    add_case("mulh_neg1", OP_MULH, 23, 1, 0, 'hFFFFFFFF, 'hFFFFFFFF, 'h0, 'h0, 'h0, 0, 'h0);
    add_case("mulhu_max", OP_MULHU, 24, 1, 0, 'hFFFFFFFF, 'hFFFFFFFF, 'h0, 'h0, 'hFFFFFFFE, 0, 'h0);
    add_case("mulh_min2", OP_MULH, 25, 1, 0, 'h80000000, 'h2, 'h0, 'h0, 'hFFFFFFFF, 0, 'h0);
    add_case("mulhu_min2", OP_MULHU, 26, 1, 0, 'h80000000, 'h2, 'h0, 'h0, 'h1, 0, 'h0);
    add_case("div_neg", OP_DIV, 27, 1, 0, 'hFFFFFFF9, 'h2, 'h0, 'h0, 'hFFFFFFFD, 0, 'h0);
    add_case("mod_neg", OP_MOD, 28, 1, 0, 'hFFFFFFF9, 'h2, 'h0, 'h0, 'hFFFFFFFF, 0, 'h0);
    add_case("divu_big", OP_DIVU, 29, 1, 0, 'hFFFFFFF9, 'h2, 'h0, 'h0, 'h7FFFFFFC, 0, 'h0);
    add_case("modu_big", OP_MODU, 30, 1, 0, 'hFFFFFFF9, 'h2, 'h0, 'h0, 'h1, 0, 'h0);
    add_case("div_zero", OP_DIV, 31, 1, 0, 'h1234, 'h0, 'h0, 'h0, 'h1234, 0, 'h0);
    add_case("modu_zero", OP_MODU, 17, 1, 1, 'hABCD, 'h5, 'h0, 'h0, 'hABCD, 0, 'h0);
    add_case("div_min", OP_DIV, 18, 1, 0, 'h80000000, 'hFFFFFFFF, 'h0, 'h0, 'h80000000, 0, 'h0);
    add_case("mod_min", OP_MOD, 3, 1, 0, 'h80000000, 'hFFFFFFFF, 'h0, 'h0, 'h0, 0, 'h0);
    add_case("div_imm", OP_DIV, 4, 1, 1, 'h64, 'h0, 'hFFFFFFFD, 'h0, 'hFFFFFFDF, 0, 'h0);
    add_case("mod_imm", OP_MOD, 5, 1, 1, 'h64, 'h0, 'hFFFFFFFD, 'h0, 'h1, 0, 'h0);
endfunction

// File: test/tb_ex_top.sv
`timescale 1ns/1ps

module tb_ex_top
    import ex_pkg::*;
();

    localparam int XLEN        = 32;
    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;

    // One table row, stimulus followed by expected response
    typedef struct packed {
        ex_op_e          op;
        reg_addr_t       rd;
        logic            wen;
        logic            use_imm;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] exp_wdata;
        logic            exp_taken;
        logic [XLEN-1:0] exp_target;
    } case_t;

    logic            clk;
    logic            rst;
    logic            flush;
    logic            in_valid;
    logic            in_ready;
    ex_ctrl_t        ctrl;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic            use_imm;
    logic            out_valid;
    logic            out_ready;
    ex_wb_t          wb;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] target;

    case_t  cases[$];
    string  case_names[$];
    int     exp_q[$];
    int     timeout_ns;
    bit     table_loaded;
    bit     random_ready;
    integer seed;
    integer rnd;

    bit              hold_pending;
    ex_wb_t          held_wb;
    logic [XLEN-1:0] held_wdata;
    logic [XLEN-1:0] held_target;

    ex_top #(
        .XLEN (XLEN)
    ) u_ex_top (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .ctrl_i      (ctrl),
        .src1_i      (src1),
        .src2_i      (src2),
        .imm_i       (imm),
        .pc_i        (pc),
        .use_imm_i   (use_imm),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .wb_o        (wb),
        .wdata_o     (wdata),
        .target_o    (target)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input string field,
                              input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected 0x%08h, actual 0x%08h", name, field, exp, act);
            abort_run();
        end
    endtask

    task automatic check_wb(input string name, input ex_wb_t exp, input ex_wb_t act);
        if (act !== exp) begin
            $write("CHECK FAILED %s wb: expected rd=%0d wen=%0b taken=%0b, ",
                   name, exp.rd, exp.wen, exp.taken);
            $display("actual rd=%0d wen=%0b taken=%0b", act.rd, act.wen, act.taken);
            abort_run();
        end
    endtask

    function automatic void add_case(input string nm, input ex_op_e op, input reg_addr_t rd,
                                     input logic wen, input logic sel_imm,
                                     input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                     input logic [XLEN-1:0] im, input logic [XLEN-1:0] pcv,
                                     input logic [XLEN-1:0] exp_wdata, input logic exp_taken,
                                     input logic [XLEN-1:0] exp_target);
        case_t row;
        row.op         = op;
        row.rd         = rd;
        row.wen        = wen;
        row.use_imm    = sel_imm;
        row.src1       = a;
        row.src2       = b;
        row.imm        = im;
        row.pc         = pcv;
        row.exp_wdata  = exp_wdata;
        row.exp_taken  = exp_taken;
        row.exp_target = exp_target;
        cases.push_back(row);
        case_names.push_back(nm);
    endfunction

`include "tb_ex_cases.svh"

    function automatic int first_row_of(ex_op_e op);
        int found;
        found = -1;
        for (int i = cases.size() - 1; i >= 0; i--) begin
            if (cases[i].op == op) found = i;
        end
        return found;
    endfunction

    // Present a row and hold it until the DUT is ready
    task automatic offer_row(input int idx, input bit expect_result);
        case_t row;
        row = cases[idx];
        @(posedge clk);
        #(DRIVE_DELAY);
        ctrl.op  = row.op;
        ctrl.rd  = row.rd;
        ctrl.wen = row.wen;
        use_imm  = row.use_imm;
        src1     = row.src1;
        src2     = row.src2;
        imm      = row.imm;
        pc       = row.pc;
        in_valid = 1'b1;
        @(negedge clk);
        while (in_ready !== 1'b1) @(negedge clk);
        // Accepted on the coming rising edge
        if (expect_result) begin
            exp_q.push_back(idx);
        end
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        #(DRIVE_DELAY);
        in_valid = 1'b0;
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic run_table();
        for (int i = 0; i < cases.size(); i++) begin
            offer_row(i, 1'b1);
        end
        idle_inputs();
        wait_results();
    endtask

    task automatic run_flush_test();
        int div_idx;
        int add_idx;
        div_idx = first_row_of(OP_DIV);
        add_idx = first_row_of(OP_ADD);
        offer_row(div_idx, 1'b0);
        idle_inputs();
        // Divide is mid-iteration here
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        flush = 1'b1;
        // Divide dropped on this edge so only the flush holds in_ready_o low
        @(posedge clk);
        @(negedge clk);
        if (in_ready !== 1'b0) begin
            $display("in_ready_o was high during the flush cycle");
            abort_run();
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        flush = 1'b0;
        @(negedge clk);
        if (in_ready !== 1'b1) begin
            $display("in_ready_o stayed low after the flush");
            abort_run();
        end
        offer_row(add_idx, 1'b1);
        idle_inputs();
        wait_results();
        // A late divide result would show up as a stray transfer
        repeat (XLEN + 8) @(negedge clk);
    endtask

    // Output side back-pressure
    always @(posedge clk) begin
        #(DRIVE_DELAY);
        if (random_ready) begin
            rnd = $random(seed);
            out_ready = rnd[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    // Compare each output transfer with the next outstanding row
    always @(negedge clk) begin : collector
        int     idx;
        case_t  row;
        ex_wb_t exp_wb;
        if (!rst && out_valid === 1'b1 && out_ready === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Output transfer seen with no instruction outstanding");
                abort_run();
            end else begin
                idx          = exp_q.pop_front();
                row          = cases[idx];
                exp_wb.rd    = row.rd;
                exp_wb.wen   = row.wen;
                exp_wb.taken = row.exp_taken;
                check_wb(case_names[idx], exp_wb, wb);
                check_word(case_names[idx], "wdata", row.exp_wdata, wdata);
                check_word(case_names[idx], "target", row.exp_target, target);
            end
        end
    end

    // Stalled output must not change
    always @(negedge clk) begin : hold_check
        if (rst) begin
            hold_pending = 1'b0;
        end else if (hold_pending && out_valid !== 1'b1) begin
            $display("out_valid_o dropped while out_ready_i was low");
            abort_run();
        end else begin
            if (hold_pending) begin
                check_wb("held output", held_wb, wb);
                check_word("held output", "wdata", held_wdata, wdata);
                check_word("held output", "target", held_target, target);
            end
            hold_pending = out_valid === 1'b1 && out_ready === 1'b0;
            held_wb      = wb;
            held_wdata   = wdata;
            held_target  = target;
        end
    end

    initial begin : watchdog
        wait (table_loaded);
        #(timeout_ns);
        $display("timeout waiting for results");
        abort_run();
    end

    initial begin
        seed         = 10482;
        clk          = 1'b0;
        rst          = 1'b1;
        flush        = 1'b0;
        in_valid     = 1'b0;
        ctrl         = '0;
        src1         = '0;
        src2         = '0;
        imm          = '0;
        pc           = '0;
        use_imm      = 1'b0;
        out_ready    = 1'b1;
        random_ready = 1'b0;
        load_cases();
        // Three times a generous per-row budget
        timeout_ns   = cases.size() * (XLEN + 8) * CLK_PERIOD * 3;
        table_loaded = 1'b1;

        repeat (4) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        @(negedge clk);
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("Wrong handshake after reset: out_valid_o=%b in_ready_o=%b",
                     out_valid, in_ready);
            abort_run();
        end

        run_table();
        random_ready = 1'b1;
        run_table();
        random_ready = 1'b0;
        run_flush_test();

        $display("All checks passed");
        $finish;
    end

endmodule

// File: verilog/ex_alu.sv
`timescale 1ns/1ps

module ex_alu
    import ex_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  ex_op_e            op_i,
    input  logic [XLEN-1:0]   src1_i,
    input  logic [XLEN-1:0]   src2_i,
    input  logic [XLEN-1:0]   opb_i,
    input  logic [XLEN-1:0]   imm_i,
    input  logic [XLEN-1:0]   pc_i,
    output logic [XLEN-1:0]   wdata_o,
    output logic              taken_o,
    output logic [XLEN-1:0]   target_o
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    link_addr;
    logic [XLEN-1:0]    pc_target;
    logic               slt_s;
    logic               slt_u;
    logic               br_eq;
    logic               br_lt_s;
    logic               br_lt_u;

    assign shamt     = opb_i[SHAMT_W-1:0];
    assign link_addr = pc_i + XLEN'(4);
    assign pc_target = pc_i + imm_i;

    // Set-less-than works on operand b, so the immediate forms come for free
    assign slt_s = $signed(src1_i) < $signed(opb_i);
    assign slt_u = src1_i < opb_i;

    // Branch conditions always look at the two registers
    assign br_eq   = src1_i == src2_i;
    assign br_lt_s = $signed(src1_i) < $signed(src2_i);
    assign br_lt_u = src1_i < src2_i;

    // Write-back data
    always_comb begin
        case (op_i)
            OP_ADD:   wdata_o = src1_i + opb_i;
            OP_SUB:   wdata_o = src1_i - opb_i;
            OP_AND:   wdata_o = src1_i & opb_i;
            OP_OR:    wdata_o = src1_i | opb_i;
            OP_XOR:   wdata_o = src1_i ^ opb_i;
            OP_NOR:   wdata_o = ~(src1_i | opb_i);
            OP_ORN:   wdata_o = src1_i | ~opb_i;
            OP_ANDN:  wdata_o = src1_i & ~opb_i;
            OP_SLL:   wdata_o = src1_i << shamt;
            OP_SRL:   wdata_o = src1_i >> shamt;
            OP_SRA:   wdata_o = $unsigned($signed(src1_i) >>> shamt);
            OP_SLT:   wdata_o = {{(XLEN-1){1'b0}}, slt_s};
            OP_SLTU:  wdata_o = {{(XLEN-1){1'b0}}, slt_u};
            OP_LUI:   wdata_o = opb_i;
            OP_PCADD: wdata_o = pc_i + opb_i;
            // Link register value
            OP_BL, OP_JIRL: wdata_o = link_addr;
            default:  wdata_o = '0;
        endcase
    end

    // Branch resolution
    always_comb begin
        taken_o  = 1'b0;
        target_o = '0;
        case (op_i)
            OP_B, OP_BL: begin
                taken_o  = 1'b1;
                target_o = pc_target;
            end
            OP_JIRL: begin
                taken_o  = 1'b1;
                target_o = src1_i + imm_i;
            end
            OP_BEQ: begin
                taken_o  = br_eq;
                target_o = pc_target;
            end
            OP_BNE: begin
                taken_o  = !br_eq;
                target_o = pc_target;
            end
            OP_BLT: begin
                taken_o  = br_lt_s;
                target_o = pc_target;
            end
            OP_BGE: begin
                taken_o  = !br_lt_s;
                target_o = pc_target;
            end
            OP_BLTU: begin
                taken_o  = br_lt_u;
                target_o = pc_target;
            end
            OP_BGEU: begin
                taken_o  = !br_lt_u;
                target_o = pc_target;
            end
            default: begin
                taken_o  = 1'b0;
                target_o = '0;
            end
        endcase
    end

endmodule

// File: verilog/ex_muldiv.sv
`timescale 1ns/1ps

module ex_muldiv
    import ex_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    input  logic            start_i,
    input  ex_op_e          op_i,
    input  logic [XLEN-1:0] opa_i,
    input  logic [XLEN-1:0] opb_i,
    output logic            busy_o,
    output logic            done_o,
    output logic [XLEN-1:0] result_o
);

    localparam int CNT_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_FINISH
    } md_state_e;

    md_state_e state_q;
    logic [CNT_W-1:0] cnt_q;

    ex_op_e          op_q;
    logic [XLEN-1:0] hi_q;
    logic [XLEN-1:0] lo_q;
    logic [XLEN-1:0] b_q;
    logic [XLEN-1:0] a_raw_q;
    logic            neg_q;
    logic            rem_neg_q;
    logic            div_zero_q;

    logic            signed_op;
    logic            a_neg;
    logic            b_neg;
    logic            is_div;
    logic [XLEN:0]   mul_sum;
    logic [XLEN:0]   div_shift;
    logic [XLEN:0]   div_diff;
    logic [XLEN-1:0] hi_nxt;
    logic [XLEN-1:0] lo_nxt;
    logic [2*XLEN-1:0] prod_fix;
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;

    // Operand signs are taken at start, the loop runs on magnitudes
    assign signed_op = op_i inside {OP_MUL, OP_MULH, OP_DIV, OP_MOD};
    assign a_neg     = signed_op && opa_i[XLEN-1];
    assign b_neg     = signed_op && opb_i[XLEN-1];
    assign is_div    = op_q inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU};

    // One iteration of shift-add multiply or restoring divide
    assign mul_sum   = {1'b0, hi_q} + (lo_q[0] ? {1'b0, b_q} : '0);
    assign div_shift = {hi_q, lo_q[XLEN-1]};
    assign div_diff  = div_shift - {1'b0, b_q};

    always_comb begin
        if (is_div) begin
            if (!div_diff[XLEN]) begin
                hi_nxt = div_diff[XLEN-1:0];
                lo_nxt = {lo_q[XLEN-2:0], 1'b1};
            end else begin
                hi_nxt = div_shift[XLEN-1:0];
                lo_nxt = {lo_q[XLEN-2:0], 1'b0};
            end
        end else begin
            hi_nxt = mul_sum[XLEN:1];
            lo_nxt = {mul_sum[0], lo_q[XLEN-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else if (flush_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    cnt_q <= '0;
                    if (start_i) state_q <= ST_RUN;
                end
                ST_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(XLEN-1)) state_q <= ST_FINISH;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && start_i) begin
            op_q       <= op_i;
            hi_q       <= '0;
            lo_q       <= a_neg ? -opa_i : opa_i;
            b_q        <= b_neg ? -opb_i : opb_i;
            a_raw_q    <= opa_i;
            neg_q      <= a_neg ^ b_neg;
            rem_neg_q  <= a_neg;
            div_zero_q <= opb_i == '0;
        end else if (state_q == ST_RUN) begin
            hi_q <= hi_nxt;
            lo_q <= lo_nxt;
        end
    end

    // Sign fix-up on the finished magnitudes
    assign prod_fix = neg_q ? -{hi_q, lo_q} : {hi_q, lo_q};
    assign quo_fix  = neg_q ? -lo_q : lo_q;
    assign rem_fix  = rem_neg_q ? -hi_q : hi_q;

    always_comb begin
        case (op_q)
            OP_MUL:               result_o = prod_fix[XLEN-1:0];
            OP_MULH, OP_MULHU:    result_o = prod_fix[2*XLEN-1:XLEN];
            OP_DIV, OP_DIVU:      result_o = div_zero_q ? a_raw_q : quo_fix;
            OP_MOD, OP_MODU:      result_o = div_zero_q ? a_raw_q : rem_fix;
            default:              result_o = '0;
        endcase
    end

    assign busy_o = state_q != ST_IDLE;
    assign done_o = state_q == ST_FINISH;

endmodule

// File: verilog/ex_pkg.sv
package ex_pkg;

    localparam int REG_ADDR_W = 5;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Every operation the execute stage understands
    typedef enum logic [5:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_ORN,
        OP_ANDN,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_LUI,
        OP_PCADD,
        OP_B,
        OP_BL,
        OP_JIRL,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_MUL,
        OP_MULH,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_MOD,
        OP_MODU
    } ex_op_e;

    // Which unit finishes the operation
    typedef enum logic {
        CLASS_SINGLE = 1'b0,
        CLASS_MULTI  = 1'b1
    } ex_class_e;

    typedef struct packed {
        ex_op_e    op;
        reg_addr_t rd;
        logic      wen;
    } ex_ctrl_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      wen;
        logic      taken;
    } ex_wb_t;

    function automatic ex_class_e op_class(ex_op_e op);
        case (op)
            OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_MOD, OP_MODU: return CLASS_MULTI;
            default: return CLASS_SINGLE;
        endcase
    endfunction

endpackage

// File: verilog/ex_result_stage.sv
`timescale 1ns/1ps

module ex_result_stage
    import ex_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    input  logic            in_valid_i,
    input  ex_ctrl_t        ctrl_i,
    input  logic            use_imm_i,
    input  logic [XLEN-1:0] src2_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] alu_wdata_i,
    input  logic            alu_taken_i,
    input  logic [XLEN-1:0] alu_target_i,
    input  logic            md_busy_i,
    input  logic            md_done_i,
    input  logic [XLEN-1:0] md_result_i,
    input  logic            out_ready_i,
    output logic            in_ready_o,
    output logic [XLEN-1:0] opb_o,
    output logic            md_start_o,
    output logic            out_valid_o,
    output ex_wb_t          wb_o,
    output logic [XLEN-1:0] wdata_o,
    output logic [XLEN-1:0] target_o
);

    logic            out_valid_q;
    ex_wb_t          wb_q;
    logic [XLEN-1:0] wdata_q;
    logic [XLEN-1:0] target_q;
    ex_wb_t          pend_wb_q;

    logic accept;
    logic is_multi;
    logic alu_load;

    assign opb_o = use_imm_i ? imm_i : src2_i;

    // Output register must be empty or draining, and no divide in flight
    assign in_ready_o = !md_busy_i && (!out_valid_q || out_ready_i) && !flush_i;
    assign accept     = in_valid_i && in_ready_o;
    assign is_multi   = op_class(ctrl_i.op) == CLASS_MULTI;
    assign md_start_o = accept && is_multi;
    assign alu_load   = accept && !is_multi;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (flush_i) begin
            out_valid_q <= 1'b0;
        end else if (alu_load || md_done_i) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // Write-back control waits here while the multi-cycle unit runs
    always_ff @(posedge clk) begin
        if (md_start_o) begin
            pend_wb_q <= '{rd: ctrl_i.rd, wen: ctrl_i.wen, taken: 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (alu_load) begin
            wb_q     <= '{rd: ctrl_i.rd, wen: ctrl_i.wen, taken: alu_taken_i};
            wdata_q  <= alu_wdata_i;
            target_q <= alu_target_i;
        end else if (md_done_i) begin
            wb_q     <= pend_wb_q;
            wdata_q  <= md_result_i;
            target_q <= '0;
        end
    end

    assign out_valid_o = out_valid_q;
    assign wb_o        = wb_q;
    assign wdata_o     = wdata_q;
    assign target_o    = target_q;

endmodule

// File: verilog/ex_top.sv
`timescale 1ns/1ps

module ex_top
    import ex_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  ex_ctrl_t        ctrl_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            use_imm_i,
    output logic            out_valid_o,
    input  logic            out_ready_i,
    output ex_wb_t          wb_o,
    output logic [XLEN-1:0] wdata_o,
    output logic [XLEN-1:0] target_o
);

    logic [XLEN-1:0] opb;
    logic [XLEN-1:0] alu_wdata;
    logic            alu_taken;
    logic [XLEN-1:0] alu_target;
    logic            md_start;
    logic            md_busy;
    logic            md_done;
    logic [XLEN-1:0] md_result;

    ex_alu #(
        .XLEN (XLEN)
    ) u_alu (
        .op_i     (ctrl_i.op),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .opb_i    (opb),
        .imm_i    (imm_i),
        .pc_i     (pc_i),
        .wdata_o  (alu_wdata),
        .taken_o  (alu_taken),
        .target_o (alu_target)
    );

    ex_muldiv #(
        .XLEN (XLEN)
    ) u_muldiv (
        .clk      (clk),
        .rst      (rst),
        .flush_i  (flush_i),
        .start_i  (md_start),
        .op_i     (ctrl_i.op),
        .opa_i    (src1_i),
        .opb_i    (opb),
        .busy_o   (md_busy),
        .done_o   (md_done),
        .result_o (md_result)
    );

    ex_result_stage #(
        .XLEN (XLEN)
    ) u_result (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .in_valid_i   (in_valid_i),
        .ctrl_i       (ctrl_i),
        .use_imm_i    (use_imm_i),
        .src2_i       (src2_i),
        .imm_i        (imm_i),
        .alu_wdata_i  (alu_wdata),
        .alu_taken_i  (alu_taken),
        .alu_target_i (alu_target),
        .md_busy_i    (md_busy),
        .md_done_i    (md_done),
        .md_result_i  (md_result),
        .out_ready_i  (out_ready_i),
        .in_ready_o   (in_ready_o),
        .opb_o        (opb),
        .md_start_o   (md_start),
        .out_valid_o  (out_valid_o),
        .wb_o         (wb_o),
        .wdata_o      (wdata_o),
        .target_o     (target_o)
    );

endmodule
